// ==== crUnit.f ====
design/crPkg.sv
design/exPipeline.sv
design/controlRegFile.sv
design/trapSequencer.sv
design/intervalTimer.sv
design/crUnit.sv
verification/crUnitTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# build and run the crUnit testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing -Wno-fatal --top-module crUnitTb \
	-f crUnit.f -Mdir obj_dir -o crUnitSim
if [ $? -ne 0 ]; then
	echo "compile step failed"
	exit 1
fi

./obj_dir/crUnitSim > "$logFile" 2>&1
runStatus=$?
cat "$logFile"
if [ $runStatus -ne 0 ]; then
	echo "simulation exited with status $runStatus"
	exit 1
fi

if grep -qx "Finished with no errors" "$logFile"; then
	exit 0
fi
exit 1

// ==== verification/crUnitTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module crUnitTb;
	import crPkg::*;

	typedef enum
	{
		kindWrite,
		kindFlushWrite,
		kindRead,
		kindHold,
		kindTrap,
		kindRte,
		kindTimer
	} rowKind;

	typedef struct
	{
		rowKind kind;
		crId id;
		crValue value;		// write data, trap address or compare value
		int stage;			// flushed stage of a flush-write
		crValue expected;	// read value, or redirect target for trap rows
	} rowT;

	logic clock;
	logic reset;
	logic hold;
	crId idEx1;
	crValue valueEx1;
	logic flushEx1;
	logic flushEx2;
	logic flushEx3;
	crId readId;
	logic trapRequest;
	trapCode trapCause;
	crValue trapAddress;
	crAddr pcNow;
	logic rteRequest;
	crValue readValue;
	crValue srValue;
	logic redirectValid;
	crAddr redirectPc;
	logic trapBusy;

	integer seed;
	int errorCount;
	int checkCount;
	int rowErrors;		// failures inside the current row
	int rowIndex;
	rowT rows[$];

	crUnit UUT (.*);

	initial
	begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	function automatic crValue randomValue();
		randomValue = {$random(seed), $random(seed)};
	endfunction

	// LR through TBR are 48 bits wide and ids past TIMCMP are not registers
	function automatic crValue expectedRead(input crId id, input crValue value);
		if (id >= crLr && id <= crTbr)
			expectedRead = {16'h0000, value[47:0]};
		else if (id <= crTimCmp)
			expectedRead = value;
		else
			expectedRead = '0;
	endfunction

	task automatic fail();
		errorCount++;
		rowErrors++;
	endtask

	task automatic checkValue(input string what, input crValue got, input crValue want);
		checkCount++;
		if (got !== want)
		begin
			$display("error at %0t ns: %s is %h, expected %h", $time, what, got, want);
			fail();
		end
	endtask

	task automatic checkAddr(input string what, input crAddr got, input crAddr want);
		checkCount++;
		if (got !== want)
		begin
			$display("error at %0t ns: %s is %h, expected %h", $time, what, got, want);
			fail();
		end
	endtask

	task automatic checkFlag(input string what, input bit got, input bit want);
		checkCount++;
		if (got !== want)
		begin
			$display("error at %0t ns: %s is %b, expected %b", $time, what, got, want);
			fail();
		end
	endtask

	task automatic addRow(input rowKind kind, input crId id, input crValue value,
		input int stage, input crValue expected);
		rows.push_back('{kind, id, value, stage, expected});
	endtask

	task automatic buildTable();
		crValue w;
		crValue older;
		crValue vbr;
		crValue trapVal;
		crValue srEnabled;
		for (int i = 0; i <= 9; i++)		// every register straight after reset
			addRow(kindRead, crId'(i), '0, 0, (i == 0) ? srResetValue : '0);
		addRow(kindRead, crImm, '0, 0, '0);
		addRow(kindRead, crZzr, '0, 0, '0);
		addRow(kindRead, 6'd20, '0, 0, '0);	// unused id
		w = randomValue();
		addRow(kindWrite, crGbr, w, 0, expectedRead(crGbr, w));
		repeat (3)
			addRow(kindRead, crGbr, '0, 0, expectedRead(crGbr, w));	// EX2, EX3, storage
		older = randomValue();
		w = randomValue();
		addRow(kindWrite, crTea, older, 0, older);
		addRow(kindWrite, crTea, w, 0, w);	// younger write to the same id
		repeat (3)
			addRow(kindRead, crTea, '0, 0, w);
		older = randomValue();
		addRow(kindWrite, crLr, older, 0, expectedRead(crLr, older));
		repeat (2)
			addRow(kindRead, crLr, '0, 0, expectedRead(crLr, older));
		for (int s = 1; s <= 3; s++)
			addRow(kindFlushWrite, crLr, randomValue(), s, expectedRead(crLr, older));
		addRow(kindWrite, crZzr, randomValue(), 0, '0);
		addRow(kindWrite, crImm, randomValue(), 0, '0);
		addRow(kindWrite, 6'd20, randomValue(), 0, '0);
		w = randomValue();
		addRow(kindHold, crSsp, w, 0, expectedRead(crSsp, w));
		vbr = randomValue();
		addRow(kindWrite, crVbr, vbr, 0, expectedRead(crVbr, vbr));
		repeat (2)
			addRow(kindRead, crVbr, '0, 0, expectedRead(crVbr, vbr));
		trapVal = randomValue();		// code in bits 7:0, pc in bits 63:16
		addRow(kindTrap, crZzr, trapVal, 0,
			crValue'(crAddr'(vbr[47:0] + {trapVal[7:0], 3'b000})));
		addRow(kindRte, crZzr, '0, 0, crValue'(trapVal[63:16]));
		srEnabled = srResetValue | (64'd1 << srIrqEnableBit);
		addRow(kindWrite, crSr, srEnabled, 0, srEnabled);
		repeat (2)
			addRow(kindRead, crSr, '0, 0, srEnabled);
		addRow(kindTimer, crTimCmp, 64'd5, 0,
			crValue'(crAddr'(vbr[47:0] + {trapTimer, 3'b000})));
	endtask

	task automatic driveIdle();
		idEx1 <= crZzr;
		valueEx1 <= '0;
		flushEx1 <= 1'b0;
		flushEx2 <= 1'b0;
		flushEx3 <= 1'b0;
		hold <= 1'b0;
		trapRequest <= 1'b0;
		rteRequest <= 1'b0;
	endtask

	// polls at falling edges until redirectValid shows up
	task automatic waitRedirect(input int limit, output bit seen);
		int n;
		seen = 1'b0;
		n = 0;
		while (!seen && n < limit)
		begin
			@(negedge clock);
			seen = redirectValid;
			n++;
		end
		if (!seen)
		begin
			$display("row %0d: no redirect arrived within %0d cycles", rowIndex, limit);
			fail();
		end
	endtask

	task automatic readBack(input crId id, input crValue want);
		@(posedge clock);
		readId <= id;
		@(negedge clock);
		checkValue("readValue", readValue, want);
	endtask

	task automatic applyRow(input rowT r);
		bit seen;
		@(posedge clock);
		driveIdle();
		readId <= r.id;
		case (r.kind)
			kindRead:
			begin
				@(negedge clock);
				checkValue("readValue", readValue, r.expected);
			end
			kindWrite:
			begin
				idEx1 <= r.id;
				valueEx1 <= r.value;
				@(negedge clock);
				checkValue("readValue", readValue, r.expected);	// forwarded from EX1
			end
			kindFlushWrite:
			begin
				idEx1 <= r.id;
				valueEx1 <= r.value;
				flushEx1 <= (r.stage == 1);
				for (int c = 1; c <= 3; c++)
				begin
					@(posedge clock);
					driveIdle();
					flushEx2 <= (r.stage == 2 && c == 1);
					flushEx3 <= (r.stage == 3 && c == 2);
				end
				@(negedge clock);
				checkValue("readValue", readValue, r.expected);	// earlier value survives
			end
			kindHold:
			begin
				idEx1 <= r.id;
				valueEx1 <= r.value;
				@(posedge clock);
				driveIdle();
				hold <= 1'b1;
				flushEx3 <= 1'b1;	// an entry that slipped into EX3 would be dropped
				repeat (3)
				begin
					@(negedge clock);
					checkValue("readValue", readValue, r.expected);
					@(posedge clock);
				end
				hold <= 1'b0;
				flushEx3 <= 1'b0;
				repeat (2)
					@(posedge clock);	// EX2 to EX3, then commit
				@(negedge clock);
				checkValue("readValue", readValue, r.expected);
			end
			kindTrap:
			begin
				trapRequest <= 1'b1;
				trapCause <= r.value[7:0];
				trapAddress <= r.value;
				pcNow <= r.value[63:16];
				@(posedge clock);
				trapRequest <= 1'b0;
				waitRedirect(8, seen);
				if (seen)
				begin
					checkAddr("redirectPc", redirectPc, r.expected[47:0]);
					checkFlag("trapBusy", trapBusy, 1'b1);
					checkFlag("srValue[28]", srValue[srIsrBit], 1'b1);
					readBack(crSpc, crValue'(r.value[63:16]));
					checkFlag("redirectValid", redirectValid, 1'b0);	// one cycle pulse
					checkFlag("trapBusy", trapBusy, 1'b0);
					readBack(crExsr, crValue'(r.value[7:0]));
					readBack(crTea, r.value);
				end
			end
			kindRte:
			begin
				rteRequest <= 1'b1;
				@(posedge clock);
				rteRequest <= 1'b0;
				waitRedirect(8, seen);
				if (seen)
				begin
					checkAddr("redirectPc", redirectPc, r.expected[47:0]);
					@(negedge clock);
					checkFlag("srValue[28]", srValue[srIsrBit], 1'b0);
				end
			end
			kindTimer:
			begin
				idEx1 <= r.id;		// compare value through the write path
				valueEx1 <= r.value;
				@(posedge clock);
				driveIdle();
				waitRedirect(60, seen);
				if (seen)
				begin
					checkAddr("redirectPc", redirectPc, r.expected[47:0]);
					readBack(crExsr, crValue'(trapTimer));
				end
			end
			default:
				;
		endcase
	endtask

	initial
	begin
		seed = 32'hbb6363b4;
		errorCount = 0;
		checkCount = 0;
		rowErrors = 0;
		rowIndex = 0;
		reset = 1'b1;
		hold = 1'b0;
		idEx1 = crZzr;
		valueEx1 = '0;
		flushEx1 = 1'b0;
		flushEx2 = 1'b0;
		flushEx3 = 1'b0;
		readId = crZzr;
		trapRequest = 1'b0;
		trapCause = '0;
		trapAddress = '0;
		pcNow = '0;
		rteRequest = 1'b0;
		buildTable();
		repeat (2)
			@(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		checkFlag("redirectValid", redirectValid, 1'b0);
		checkFlag("trapBusy", trapBusy, 1'b0);
		for (int i = 0; i < rows.size(); i++)
		begin
			rowIndex = i;
			rowErrors = 0;
			applyRow(rows[i]);
			$display("row %0d %s %s", i, rows[i].kind.name(),
				(rowErrors == 0) ? "passed" : "failed");
		end
		$display("%0d rows, %0d checks, %0d errors", rows.size(), checkCount, errorCount);
		if (errorCount == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== design/crUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module crUnit
(
	input wire clock,
	input wire reset,
	input wire hold,
	input wire crPkg::crId idEx1,
	input wire crPkg::crValue valueEx1,
	input wire flushEx1,
	input wire flushEx2,
	input wire flushEx3,
	input wire crPkg::crId readId,
	input wire trapRequest,
	input wire crPkg::trapCode trapCause,
	input wire crPkg::crValue trapAddress,
	input wire crPkg::crAddr pcNow,
	input wire rteRequest,
	output crPkg::crValue readValue,
	output crPkg::crValue srValue,
	output logic redirectValid,
	output crPkg::crAddr redirectPc,
	output logic trapBusy
);
	import crPkg::*;

	// write path, EX2 and EX3 already masked by their flushes
	crId idEx2;
	crValue valueEx2;
	crId idEx3;
	crValue valueEx3;

	// trap side
	logic trapWrite;
	crAddr trapSpc;
	crValue trapExsr;
	crValue trapTea;
	logic isrSet;
	logic isrClear;
	logic trapFlush;
	logic timerIrq;

	crAddr vbrValue;
	crAddr spcValue;
	crValue timCmpValue;

	exPipeline pipe
	(
		.clock(clock), .reset(reset), .hold(hold),
		.idEx1(idEx1), .valueEx1(valueEx1),
		.flushEx1(flushEx1), .flushEx2(flushEx2), .flushEx3(flushEx3),
		.trapFlush(trapFlush),
		.idEx2(idEx2), .valueEx2(valueEx2),
		.idEx3(idEx3), .valueEx3(valueEx3)
	);

	controlRegFile regs
	(
		.clock(clock), .reset(reset), .hold(hold),
		.readId(readId),
		.idEx1(idEx1), .valueEx1(valueEx1), .flushEx1(flushEx1),
		.idEx2(idEx2), .valueEx2(valueEx2),
		.idEx3(idEx3), .valueEx3(valueEx3),
		.trapWrite(trapWrite), .trapSpc(trapSpc),
		.trapExsr(trapExsr), .trapTea(trapTea),
		.isrSet(isrSet), .isrClear(isrClear),
		.readValue(readValue), .srValue(srValue),
		.vbrValue(vbrValue), .spcValue(spcValue),
		.timCmpValue(timCmpValue)
	);

	trapSequencer seq
	(
		.clock(clock), .reset(reset), .hold(hold),
		.trapRequest(trapRequest), .trapCause(trapCause),
		.trapAddress(trapAddress), .pcNow(pcNow),
		.rteRequest(rteRequest), .timerIrq(timerIrq),
		.srValue(srValue), .vbrValue(vbrValue), .spcValue(spcValue),
		.trapWrite(trapWrite), .trapSpc(trapSpc),
		.trapExsr(trapExsr), .trapTea(trapTea),
		.isrSet(isrSet), .isrClear(isrClear), .trapFlush(trapFlush),
		.redirectValid(redirectValid), .redirectPc(redirectPc),
		.trapBusy(trapBusy)
	);

	intervalTimer timer
	(
		.clock(clock), .reset(reset), .hold(hold),
		.timCmpValue(timCmpValue),
		.timerIrq(timerIrq)
	);

endmodule

`default_nettype wire

// ==== design/intervalTimer.sv ====
`timescale 1ns/1ns
`default_nettype none

module intervalTimer
(
	input wire clock,
	input wire reset,
	input wire hold,
	input wire crPkg::crValue timCmpValue,
	output logic timerIrq
);
	import crPkg::*;

	crValue count;		// cycles since last restart
	logic hit;

	// zero compare value disables the timer
	assign hit = (timCmpValue != '0) && (count == timCmpValue);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			count <= '0;
			timerIrq <= 1'b0;
		end
		else if (!hold)		// frozen under hold
		begin
			timerIrq <= hit;	// one cycle pulse
			if (timCmpValue == '0)
				count <= '0;
			else if (hit)
				count <= '0;	// restart the interval
			else
				count <= count + 64'd1;
		end
	end

endmodule

`default_nettype wire

// ==== design/trapSequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module trapSequencer
(
	input wire clock,
	input wire reset,
	input wire hold,
	input wire trapRequest,
	input wire crPkg::trapCode trapCause,
	input wire crPkg::crValue trapAddress,
	input wire crPkg::crAddr pcNow,
	input wire rteRequest,
	input wire timerIrq,
	input wire crPkg::crValue srValue,
	input wire crPkg::crAddr vbrValue,
	input wire crPkg::crAddr spcValue,
	output logic trapWrite,
	output crPkg::crAddr trapSpc,
	output crPkg::crValue trapExsr,
	output crPkg::crValue trapTea,
	output logic isrSet,
	output logic isrClear,
	output logic trapFlush,
	output logic redirectValid,
	output crPkg::crAddr redirectPc,
	output logic trapBusy
);
	import crPkg::*;

	trapStateT state;		// registered state
	trapStateT phase;		// state as seen this cycle, idle turns into save on acceptance
	trapStateT nextState;

	logic timerPending;		// timer pulse waiting to be taken
	logic timerTake;
	logic canAccept;
	trapCode entryCode;		// cause of the trap being accepted
	trapCode codeReg;		// held for the vector computation

	assign canAccept = (state == trapIdle) && !hold;
	// explicit trap request beats the timer
	assign timerTake = canAccept && !trapRequest && timerPending
		&& srValue[srIrqEnableBit] && !srValue[srIsrBit];
	assign entryCode = trapRequest ? trapCause : trapTimer;

	always_comb
	begin
		phase = state;
		if (canAccept && (trapRequest || timerTake))
			phase = trapSave;
	end

	always_comb
	begin
		case (phase)
			trapIdle:	nextState = (canAccept && rteRequest) ? trapReturn : trapIdle;
			trapSave:	nextState = trapVector;
			trapVector:	nextState = trapIdle;
			trapReturn:	nextState = trapIdle;
			default:	nextState = trapIdle;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= trapIdle;
			timerPending <= 1'b0;
		end
		else if (!hold)
		begin
			state <= nextState;
			timerPending <= timerIrq || (timerPending && !timerTake);
		end
	end

	always_ff @(posedge clock)
	begin
		if (phase == trapSave)
			codeReg <= entryCode;
	end

	// state save happens on the acceptance edge
	assign trapWrite = (phase == trapSave);
	assign isrSet = (phase == trapSave);
	assign trapFlush = (phase == trapSave);		// drops everything in flight
	assign trapSpc = pcNow;
	assign trapExsr = crValue'(entryCode);
	assign trapTea = trapRequest ? trapAddress : '0;	// timer has no fault address

	assign isrClear = (state == trapReturn) && !hold;	// at the end of the return cycle

	assign redirectValid = (state == trapVector) || (state == trapReturn);
	// vector entries are 8 bytes apart, wraps at 48 bits
	assign redirectPc = (state == trapReturn) ? spcValue
		: vbrValue + crAddr'({codeReg, 3'b000});

	assign trapBusy = (state != trapIdle);

endmodule

`default_nettype wire

// ==== design/controlRegFile.sv ====
`timescale 1ns/1ns
`default_nettype none

module controlRegFile
(
	input wire clock,
	input wire reset,
	input wire hold,
	input wire crPkg::crId readId,
	input wire crPkg::crId idEx1,
	input wire crPkg::crValue valueEx1,
	input wire flushEx1,
	input wire crPkg::crId idEx2,
	input wire crPkg::crValue valueEx2,
	input wire crPkg::crId idEx3,
	input wire crPkg::crValue valueEx3,
	input wire trapWrite,
	input wire crPkg::crAddr trapSpc,
	input wire crPkg::crValue trapExsr,
	input wire crPkg::crValue trapTea,
	input wire isrSet,
	input wire isrClear,
	output crPkg::crValue readValue,
	output crPkg::crValue srValue,
	output crPkg::crAddr vbrValue,
	output crPkg::crAddr spcValue,
	output crPkg::crValue timCmpValue
);
	import crPkg::*;

	crValue srReg;
	crValue exsrReg;
	crValue teaReg;
	crValue timCmpReg;
	crAddr lrReg;
	crAddr spcReg;
	crAddr sspReg;
	crAddr vbrReg;
	crAddr gbrReg;
	crAddr tbrReg;

	crValue storeValue;		// storage side of the read mux
	logic readable;			// readId names a real register

	assign srValue = srReg;
	assign vbrValue = vbrReg;
	assign spcValue = spcReg;
	assign timCmpValue = timCmpReg;

	// forwarded values must look like what storage would return
	function automatic crValue fitValue(input crId id, input crValue value);
		case (id)
			crLr, crSpc, crSsp, crVbr, crGbr, crTbr:
				fitValue = {16'h0000, value[47:0]};
			default:
				fitValue = value;
		endcase
	endfunction

	always_comb
	begin
		readable = 1'b1;
		case (readId)
			crSr:		storeValue = srReg;
			crLr:		storeValue = {16'h0000, lrReg};
			crSpc:		storeValue = {16'h0000, spcReg};
			crSsp:		storeValue = {16'h0000, sspReg};
			crVbr:		storeValue = {16'h0000, vbrReg};
			crGbr:		storeValue = {16'h0000, gbrReg};
			crTbr:		storeValue = {16'h0000, tbrReg};
			crTea:		storeValue = teaReg;
			crExsr:		storeValue = exsrReg;
			crTimCmp:	storeValue = timCmpReg;
			default:
			begin
				storeValue = '0;
				readable = 1'b0;	// crImm, crZzr and unknown ids are never forwarded
			end
		endcase

		readValue = storeValue;
		// youngest write wins, so EX1 is checked last
		if (readable)
		begin
			if (idEx3 == readId)
				readValue = fitValue(readId, valueEx3);
			if (idEx2 == readId)
				readValue = fitValue(readId, valueEx2);
			if (idEx1 == readId && !flushEx1)
				readValue = fitValue(readId, valueEx1);
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			srReg <= srResetValue;
			exsrReg <= '0;
			teaReg <= '0;
			timCmpReg <= '0;
			lrReg <= '0;
			spcReg <= '0;
			sspReg <= '0;
			vbrReg <= '0;
			gbrReg <= '0;
			tbrReg <= '0;
		end
		else if (!hold)
		begin
			// commit of the EX3 entry
			case (idEx3)
				crSr:		srReg <= valueEx3;
				crLr:		lrReg <= valueEx3[47:0];
				crSpc:		spcReg <= valueEx3[47:0];
				crSsp:		sspReg <= valueEx3[47:0];
				crVbr:		vbrReg <= valueEx3[47:0];
				crGbr:		gbrReg <= valueEx3[47:0];
				crTbr:		tbrReg <= valueEx3[47:0];
				crTea:		teaReg <= valueEx3;
				crExsr:		exsrReg <= valueEx3;
				crTimCmp:	timCmpReg <= valueEx3;
				default:	;		// crZzr, crImm, unknown
			endcase

			// trap side comes later and wins on a clash
			if (trapWrite)
			begin
				spcReg <= trapSpc;
				exsrReg <= trapExsr;
				teaReg <= trapTea;
			end
			if (isrSet)
				srReg[srIsrBit] <= 1'b1;	// enter handler
			if (isrClear)
				srReg[srIsrBit] <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== design/exPipeline.sv ====
`timescale 1ns/1ns
`default_nettype none

module exPipeline
(
	input wire clock,
	input wire reset,
	input wire hold,
	input wire crPkg::crId idEx1,
	input wire crPkg::crValue valueEx1,
	input wire flushEx1,
	input wire flushEx2,
	input wire flushEx3,
	input wire trapFlush,
	output crPkg::crId idEx2,
	output crPkg::crValue valueEx2,
	output crPkg::crId idEx3,
	output crPkg::crValue valueEx3
);
	import crPkg::*;

	crId stage2Id;			// entry sitting in EX2
	crValue stage2Value;
	crId stage3Id;			// entry sitting in EX3
	crValue stage3Value;

	logic kill2;
	logic kill3;

	// a stage flush or a trap turns the entry into a null write
	assign kill2 = flushEx2 || trapFlush;
	assign kill3 = flushEx3 || trapFlush;

	// masked views, also what the read port forwards from
	assign idEx2 = kill2 ? crZzr : stage2Id;
	assign valueEx2 = kill2 ? '0 : stage2Value;
	assign idEx3 = kill3 ? crZzr : stage3Id;	// commit sees the masked id
	assign valueEx3 = kill3 ? '0 : stage3Value;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			stage2Id <= crZzr;
			stage2Value <= '0;
			stage3Id <= crZzr;
			stage3Value <= '0;
		end
		else if (!hold)		// hold freezes both stages
		begin
			// flushed EX1 entry is never captured
			if (flushEx1 || trapFlush)
			begin
				stage2Id <= crZzr;
				stage2Value <= '0;
			end
			else
			begin
				stage2Id <= idEx1;
				stage2Value <= valueEx1;
			end
			stage3Id <= idEx2;			// already masked
			stage3Value <= valueEx2;
		end
	end

endmodule

`default_nettype wire

// ==== design/crPkg.sv ====
`default_nettype none

package crPkg;

	// field widths
	localparam int crIdBits = 6;
	localparam int crValueBits = 64;
	localparam int crAddrBits = 48;		// virtual address space
	localparam int trapCodeBits = 8;

	typedef logic [crIdBits-1:0] crId;
	typedef logic [crValueBits-1:0] crValue;
	typedef logic [crAddrBits-1:0] crAddr;		// LR, SPC, SSP, VBR, GBR, TBR
	typedef logic [trapCodeBits-1:0] trapCode;

	// register IDs as seen on the write and read ports
	localparam crId crSr = 6'd0;		// status
	localparam crId crLr = 6'd1;		// link
	localparam crId crSpc = 6'd2;		// saved pc
	localparam crId crSsp = 6'd3;		// saved sp
	localparam crId crVbr = 6'd4;		// vector base
	localparam crId crGbr = 6'd5;
	localparam crId crTbr = 6'd6;
	localparam crId crTea = 6'd7;		// trap address
	localparam crId crExsr = 6'd8;		// exception status
	localparam crId crTimCmp = 6'd9;	// timer compare

	// ids that name no register and read as zero
	localparam crId crImm = 6'd62;
	localparam crId crZzr = 6'd63;		// null destination

	// SR comes out of reset with bit 30 set
	localparam crValue srResetValue = 64'h0000_0000_4000_0000;

	localparam int srIsrBit = 28;		// set while in a handler
	localparam int srIrqEnableBit = 1;	// timer interrupt enable

	localparam trapCode trapTimer = 8'h80;

	// trap sequencer states
	typedef enum logic [1:0]
	{
		trapIdle,
		trapSave,		// acceptance cycle, state is written
		trapVector,		// redirect through VBR
		trapReturn		// redirect to SPC
	} trapStateT;

endpackage

`default_nettype wire
